// File: hw/immu_pkg.sv
package immu_pkg;

   // Datapath and page geometry
   localparam int ADDR_W           = 32;
   localparam int PAGE_BITS        = 13;
   localparam int VPN_W            = ADDR_W - PAGE_BITS;
   // A miss passes the low 16 MB of the virtual address straight through
   localparam int MISS_OFFSET_BITS = 24;

   // SPR address layout
   localparam int          SPR_ADDR_W     = 16;
   localparam int          SPR_GROUP_LSB  = 11;
   localparam logic [4:0]  SPR_GROUP_IMMU = 5'd2;
   localparam logic [10:0] SPR_MATCH_BASE = 11'h200;
   localparam logic [10:0] SPR_TRANS_BASE = 11'h280;
   // Bits 10:9 select the TLB region, bit 7 splits match from translate
   localparam int          SPR_TLB_SEL_HI = 10;
   localparam int          SPR_TLB_SEL_LO = 9;
   localparam int          SPR_ARRAY_BIT  = 7;

   // Match entry fields
   localparam int MATCH_VPN_LSB = 13;
   localparam int MATCH_V_BIT   = 0;

   // Translate entry fields
   localparam int TRANS_PPN_LSB = 13;
   localparam int TRANS_UXE_BIT = 7;
   localparam int TRANS_SXE_BIT = 6;
   localparam int TRANS_CI_BIT  = 1;

   // Translate entry as seen by the translation logic
   typedef struct packed {
      logic [VPN_W-1:0] ppn;
      logic             uxe;
      logic             sxe;
      logic             ci;
   } itlb_trans_t;

endpackage

// File: hw/itlb_port_if.sv
interface itlb_port_if #(
   parameter int SET_WIDTH = 6
);
   import immu_pkg::*;

   // Entry index, shared by read and write
   logic [SET_WIDTH-1:0] index;
   logic                 we;
   logic [ADDR_W-1:0]    wdata;
   // Entry at the index of the previous cycle
   logic [ADDR_W-1:0]    rdata;

   modport ctrl (
      output index,
      output we,
      output wdata,
      input  rdata
   );

   modport array (
      input  index,
      input  we,
      input  wdata,
      output rdata
   );

endinterface

// File: hw/immu_spr_ctrl.sv
module immu_spr_ctrl #(
   parameter int SET_WIDTH = 6
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            enable_i,
   input  logic [immu_pkg::SPR_ADDR_W-1:0] spr_addr_i,
   input  logic                            spr_we_i,
   input  logic                            spr_stb_i,
   input  logic [immu_pkg::ADDR_W-1:0]     spr_dat_i,
   input  logic [immu_pkg::ADDR_W-1:0]     virt_addr_i,
   output logic [immu_pkg::ADDR_W-1:0]     spr_dat_o,
   output logic                            spr_ack_o,
   output logic                            busy_o,
   itlb_port_if.ctrl                       match_port_o,
   itlb_port_if.ctrl                       trans_port_o
);
   import immu_pkg::*;

   logic                 in_group;
   logic                 tlb_sel;
   logic                 match_cs;
   logic                 trans_cs;
   logic                 match_cs_r;
   logic                 trans_cs_r;
   logic                 match_tx;
   logic                 trans_tx;
   logic                 match_tx_r;
   logic                 trans_tx_r;
   logic                 ack_q;
   logic                 ack_r;
   logic                 ack_first;
   logic [ADDR_W-1:0]    rd_data;
   logic [ADDR_W-1:0]    rd_data_r;
   logic [SET_WIDTH-1:0] spr_index;
   logic [SET_WIDTH-1:0] fetch_index;

   // Address decode
   assign in_group = spr_addr_i[SPR_ADDR_W-1:SPR_GROUP_LSB] == SPR_GROUP_IMMU;
   assign tlb_sel  = |spr_addr_i[SPR_TLB_SEL_HI:SPR_TLB_SEL_LO];

   assign match_cs = spr_stb_i & in_group & tlb_sel &
                     (spr_addr_i[SPR_ARRAY_BIT] == SPR_MATCH_BASE[SPR_ARRAY_BIT]);
   assign trans_cs = spr_stb_i & in_group & tlb_sel &
                     (spr_addr_i[SPR_ARRAY_BIT] == SPR_TRANS_BASE[SPR_ARRAY_BIT]);

   always_ff @(posedge clk) begin
      if (rst) begin
         match_cs_r <= 1'b0;
         trans_cs_r <= 1'b0;
         match_tx_r <= 1'b0;
         trans_tx_r <= 1'b0;
      end else begin
         match_cs_r <= match_cs;
         trans_cs_r <= trans_cs;
         match_tx_r <= match_tx;
         trans_tx_r <= trans_tx;
      end
   end

   // Access start is the first cycle of a select
   assign match_tx = match_cs & ~match_cs_r;
   assign trans_tx = trans_cs & ~trans_cs_r;

   // The RAM outputs are not valid for fetch during tx and the cycle after
   assign busy_o = enable_i & (match_tx | trans_tx | match_tx_r | trans_tx_r);

   // Array ports, SPR address wins during tx
   assign spr_index   = spr_addr_i[SET_WIDTH-1:0];
   assign fetch_index = virt_addr_i[PAGE_BITS +: SET_WIDTH];

   assign match_port_o.index = match_tx ? spr_index : fetch_index;
   assign match_port_o.we    = match_tx & spr_we_i;
   assign match_port_o.wdata = spr_dat_i;

   assign trans_port_o.index = trans_tx ? spr_index : fetch_index;
   assign trans_port_o.we    = trans_tx & spr_we_i;
   assign trans_port_o.wdata = spr_dat_i;

   // Acknowledge any group access one cycle after strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
         ack_r <= 1'b0;
      end else begin
         ack_q <= spr_stb_i & in_group;
         ack_r <= ack_q;
      end
   end

   assign ack_first = ack_q & ~ack_r;
   assign spr_ack_o = ack_q & spr_stb_i & in_group;

   // Unmapped group addresses read as zero
   assign rd_data = match_cs_r ? match_port_o.rdata :
                    trans_cs_r ? trans_port_o.rdata : '0;

   // Index returns to fetch after tx, so keep the first read word
   always_ff @(posedge clk) begin
      if (ack_first) begin
         rd_data_r <= rd_data;
      end
   end

   assign spr_dat_o = ack_first ? rd_data : rd_data_r;

   a_sel_exclusive: assert property (
      @(posedge clk) disable iff (rst) !(match_cs && trans_cs)
   );

   a_busy_after_tx: assert property (
      @(posedge clk) disable iff (rst) (match_tx || trans_tx) ##1 enable_i |-> busy_o
   );

endmodule

// File: hw/itlb_match_array.sv
module itlb_match_array #(
   parameter int SET_WIDTH = 6
) (
   input  logic                        clk,
   input  logic [immu_pkg::ADDR_W-1:0] virt_addr_match_i,
   itlb_port_if.array                  port_i,
   output logic                        hit_o
);
   import immu_pkg::*;

   localparam int ENTRIES = 2 ** SET_WIDTH;

   logic [ADDR_W-1:0] mem [ENTRIES];
   logic [ADDR_W-1:0] rdata_q;
   logic              vpn_eq;
   logic              valid;

   // Single port RAM, read returns the old entry on a write
   always_ff @(posedge clk) begin
      if (port_i.we) begin
         mem[port_i.index] <= port_i.wdata;
      end
      rdata_q <= mem[port_i.index];
   end

   assign port_i.rdata = rdata_q;

   // Compare the stored VPN against the address of the lookup cycle
   assign vpn_eq = rdata_q[ADDR_W-1:MATCH_VPN_LSB] ==
                   virt_addr_match_i[ADDR_W-1:MATCH_VPN_LSB];
   assign valid  = rdata_q[MATCH_V_BIT];
   assign hit_o  = valid & vpn_eq;

   a_we_index_known: assert property (
      @(posedge clk) port_i.we |-> !$isunknown(port_i.index)
   );

endmodule

// File: hw/itlb_trans_array.sv
module itlb_trans_array #(
   parameter int SET_WIDTH = 6
) (
   input  logic                  clk,
   itlb_port_if.array            port_i,
   output immu_pkg::itlb_trans_t entry_o
);
   import immu_pkg::*;

   localparam int ENTRIES = 2 ** SET_WIDTH;

   logic [ADDR_W-1:0] mem [ENTRIES];
   logic [ADDR_W-1:0] rdata_q;

   always_ff @(posedge clk) begin
      if (port_i.we) begin
         mem[port_i.index] <= port_i.wdata;
      end
      rdata_q <= mem[port_i.index];
   end

   // Raw word goes back for SPR reads
   assign port_i.rdata = rdata_q;

   // Only the fields used by translation are unpacked
   always_comb begin
      entry_o.ppn = rdata_q[ADDR_W-1:TRANS_PPN_LSB];
      entry_o.uxe = rdata_q[TRANS_UXE_BIT];
      entry_o.sxe = rdata_q[TRANS_SXE_BIT];
      entry_o.ci  = rdata_q[TRANS_CI_BIT];
   end

endmodule

// File: hw/immu_translate.sv
module immu_translate (
   input  logic                        hit_i,
   input  immu_pkg::itlb_trans_t       entry_i,
   input  logic [immu_pkg::ADDR_W-1:0] virt_addr_match_i,
   input  logic                        supervisor_mode_i,
   input  logic                        busy_i,
   output logic [immu_pkg::ADDR_W-1:0] phys_addr_o,
   output logic                        cache_inhibit_o,
   output logic                        tlb_miss_o,
   output logic                        pagefault_o
);
   import immu_pkg::*;

   logic sxe;
   logic uxe;
   logic exec_ok;

   always_comb begin
      phys_addr_o     = '0;
      cache_inhibit_o = 1'b0;
      sxe             = 1'b0;
      uxe             = 1'b0;
      if (hit_i) begin
         phys_addr_o     = {entry_i.ppn, virt_addr_match_i[PAGE_BITS-1:0]};
         cache_inhibit_o = entry_i.ci;
         sxe             = entry_i.sxe;
         uxe             = entry_i.uxe;
      end else begin
         // Untranslated fallback keeps the low 24 bits
         phys_addr_o[MISS_OFFSET_BITS-1:0] = virt_addr_match_i[MISS_OFFSET_BITS-1:0];
      end
   end

   // Execute permission for the current privilege level
   assign exec_ok = supervisor_mode_i ? sxe : uxe;

   // Outputs are stale while an SPR access owns the arrays
   assign tlb_miss_o  = ~hit_i & ~busy_i;
   assign pagefault_o = ~exec_ok & ~busy_i;

   a_miss_no_ci: assert final (!tlb_miss_o || !cache_inhibit_o);

endmodule

// File: hw/immu_top.sv
module immu_top #(
   parameter int SET_WIDTH = 6
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            enable_i,
   input  logic                            supervisor_mode_i,
   input  logic [immu_pkg::ADDR_W-1:0]     virt_addr_i,
   input  logic [immu_pkg::ADDR_W-1:0]     virt_addr_match_i,
   input  logic [immu_pkg::SPR_ADDR_W-1:0] spr_addr_i,
   input  logic                            spr_we_i,
   input  logic                            spr_stb_i,
   input  logic [immu_pkg::ADDR_W-1:0]     spr_dat_i,
   output logic                            busy_o,
   output logic [immu_pkg::ADDR_W-1:0]     phys_addr_o,
   output logic                            cache_inhibit_o,
   output logic                            tlb_miss_o,
   output logic                            pagefault_o,
   output logic [immu_pkg::ADDR_W-1:0]     spr_dat_o,
   output logic                            spr_ack_o
);
   import immu_pkg::*;

   logic        hit;
   itlb_trans_t trans_entry;

   itlb_port_if #(.SET_WIDTH(SET_WIDTH)) match_port ();
   itlb_port_if #(.SET_WIDTH(SET_WIDTH)) trans_port ();

   immu_spr_ctrl #(
      .SET_WIDTH (SET_WIDTH)
   ) i_immu_spr_ctrl (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .spr_addr_i   (spr_addr_i),
      .spr_we_i     (spr_we_i),
      .spr_stb_i    (spr_stb_i),
      .spr_dat_i    (spr_dat_i),
      .virt_addr_i  (virt_addr_i),
      .spr_dat_o    (spr_dat_o),
      .spr_ack_o    (spr_ack_o),
      .busy_o       (busy_o),
      .match_port_o (match_port.ctrl),
      .trans_port_o (trans_port.ctrl)
   );

   itlb_match_array #(
      .SET_WIDTH (SET_WIDTH)
   ) i_itlb_match_array (
      .clk               (clk),
      .virt_addr_match_i (virt_addr_match_i),
      .port_i            (match_port.array),
      .hit_o             (hit)
   );

   itlb_trans_array #(
      .SET_WIDTH (SET_WIDTH)
   ) i_itlb_trans_array (
      .clk     (clk),
      .port_i  (trans_port.array),
      .entry_o (trans_entry)
   );

   immu_translate i_immu_translate (
      .hit_i             (hit),
      .entry_i           (trans_entry),
      .virt_addr_match_i (virt_addr_match_i),
      .supervisor_mode_i (supervisor_mode_i),
      .busy_i            (busy_o),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .tlb_miss_o        (tlb_miss_o),
      .pagefault_o       (pagefault_o)
   );

endmodule

// File: verification/immu_tb.sv
module immu_tb;

   localparam int SET_WIDTH   = 6;
   localparam int ENTRIES     = 2 ** SET_WIDTH;
   localparam int ACK_TIMEOUT = 20;
   localparam int MAX_CYCLES  = 20000;

   logic        clk;
   logic        rst;
   logic        enable_i;
   logic        supervisor_mode_i;
   logic [31:0] virt_addr_i;
   logic [31:0] virt_addr_match_i;
   logic [15:0] spr_addr_i;
   logic        spr_we_i;
   logic        spr_stb_i;
   logic [31:0] spr_dat_i;
   logic        busy_o;
   logic [31:0] phys_addr_o;
   logic        cache_inhibit_o;
   logic        tlb_miss_o;
   logic        pagefault_o;
   logic [31:0] spr_dat_o;
   logic        spr_ack_o;

   // Reference copy of everything written over the SPR bus
   logic [31:0] model_match [ENTRIES];
   logic [31:0] model_trans [ENTRIES];

   logic [31:0] exp_phys;
   logic        exp_miss;
   logic        exp_ci;
   logic        exp_pf;
   logic [31:0] exp_rdata;
   logic        lk_check;
   logic        rd_check;
   string       test_name;
   int          value_errors;
   int          timeout_errors;
   integer      seed;

   // Group 2 lives in SPR address bits 15:11
   logic        in_group;
   logic        tlb_access;

   assign in_group   = spr_addr_i[15:11] == 5'd2;
   assign tlb_access = in_group && (spr_addr_i[10] || spr_addr_i[9]);

   immu_top #(
      .SET_WIDTH (SET_WIDTH)
   ) i_immu_top (
      .clk               (clk),
      .rst               (rst),
      .enable_i          (enable_i),
      .supervisor_mode_i (supervisor_mode_i),
      .virt_addr_i       (virt_addr_i),
      .virt_addr_match_i (virt_addr_match_i),
      .spr_addr_i        (spr_addr_i),
      .spr_we_i          (spr_we_i),
      .spr_stb_i         (spr_stb_i),
      .spr_dat_i         (spr_dat_i),
      .busy_o            (busy_o),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .tlb_miss_o        (tlb_miss_o),
      .pagefault_o       (pagefault_o),
      .spr_dat_o         (spr_dat_o),
      .spr_ack_o         (spr_ack_o)
   );

   always #5 clk = ~clk;

   task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      value_errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
   endtask

   // Lookup results are valid in the cycle after the index edge
   a_lookup_phys: assert property (@(posedge clk) disable iff (rst)
      lk_check |-> phys_addr_o == exp_phys)
      else report_mismatch("phys_addr", exp_phys, $sampled(phys_addr_o));
   a_lookup_miss: assert property (@(posedge clk) disable iff (rst)
      lk_check |-> tlb_miss_o == exp_miss)
      else report_mismatch("tlb_miss", 32'(exp_miss), 32'($sampled(tlb_miss_o)));
   a_lookup_ci: assert property (@(posedge clk) disable iff (rst)
      lk_check |-> cache_inhibit_o == exp_ci)
      else report_mismatch("cache_inhibit", 32'(exp_ci), 32'($sampled(cache_inhibit_o)));
   a_lookup_pf: assert property (@(posedge clk) disable iff (rst)
      lk_check |-> pagefault_o == exp_pf)
      else report_mismatch("pagefault", 32'(exp_pf), 32'($sampled(pagefault_o)));

   // Covers both the first ack cycle and the held data after it
   a_read_data: assert property (@(posedge clk) disable iff (rst)
      rd_check && spr_ack_o |-> spr_dat_o == exp_rdata)
      else report_mismatch("read data", exp_rdata, $sampled(spr_dat_o));

   a_ack_in_group: assert property (@(posedge clk) disable iff (rst)
      $rose(spr_stb_i) && in_group |=> spr_ack_o)
      else report_mismatch("ack", 32'd1, 32'($sampled(spr_ack_o)));
   a_ack_held: assert property (@(posedge clk) disable iff (rst)
      spr_ack_o && spr_stb_i |=> !spr_stb_i || spr_ack_o)
      else report_mismatch("ack held", 32'd1, 32'($sampled(spr_ack_o)));
   a_no_ack_outside: assert property (@(posedge clk) disable iff (rst)
      spr_stb_i && !in_group |-> !spr_ack_o)
      else report_mismatch("ack", 32'd0, 32'($sampled(spr_ack_o)));

   a_busy_tx: assert property (@(posedge clk) disable iff (rst)
      enable_i && $rose(spr_stb_i) && tlb_access |-> busy_o)
      else report_mismatch("busy in tx", 32'd1, 32'($sampled(busy_o)));
   a_busy_after_tx: assert property (@(posedge clk) disable iff (rst)
      enable_i && $rose(spr_stb_i) && tlb_access |=> busy_o)
      else report_mismatch("busy after tx", 32'd1, 32'($sampled(busy_o)));
   a_busy_disabled: assert property (@(posedge clk) disable iff (rst)
      !enable_i |-> !busy_o)
      else report_mismatch("busy disabled", 32'd0, 32'($sampled(busy_o)));
   a_busy_gates: assert property (@(posedge clk) disable iff (rst)
      busy_o |-> !tlb_miss_o && !pagefault_o)
      else report_mismatch("miss/fault while busy", 32'd0,
                           32'({$sampled(tlb_miss_o), $sampled(pagefault_o)}));

   function automatic logic [31:0] make_match(input logic [18:0] vpn, input logic valid);
      return {vpn, 12'h000, valid};
   endfunction

   function automatic logic [31:0] make_trans(input logic [18:0] ppn, input logic uxe,
                                              input logic sxe, input logic ci);
      return {ppn, 5'h00, uxe, sxe, 4'h0, ci, 1'b0};
   endfunction

   // One SPR bus access with strobe held two cycles past the first ack
   task automatic spr_access(input logic [15:0] addr, input logic we,
                             input logic [31:0] wdata, input logic expect_ack);
      logic acked;
      acked = 1'b0;
      @(negedge clk);
      spr_addr_i = addr;
      spr_we_i   = we;
      spr_dat_i  = wdata;
      spr_stb_i  = 1'b1;
      for (int n = 0; n < ACK_TIMEOUT && !acked; n++) begin
         @(negedge clk);
         acked = spr_ack_o;
      end
      if (acked) begin
         @(negedge clk);
         @(negedge clk);
      end else if (expect_ack) begin
         timeout_errors++;
         $display("SPR access to address %h was not acknowledged in time", addr);
      end
      spr_stb_i = 1'b0;
      spr_we_i  = 1'b0;
   endtask

   task automatic spr_write(input logic [15:0] addr, input logic [31:0] data);
      spr_access(addr, 1'b1, data, 1'b1);
   endtask

   task automatic spr_read(input logic [15:0] addr, input logic [31:0] expected,
                           input logic expect_ack);
      exp_rdata = expected;
      rd_check  = expect_ack;
      spr_access(addr, 1'b0, 32'h0, expect_ack);
      rd_check  = 1'b0;
   endtask

   task automatic write_entry(input logic [SET_WIDTH-1:0] idx, input logic [31:0] match_word,
                              input logic [31:0] trans_word);
      model_match[idx] = match_word;
      model_trans[idx] = trans_word;
      spr_write(16'h1200 + 16'(idx), match_word);
      spr_write(16'h1280 + 16'(idx), trans_word);
   endtask

   task automatic set_expect(input logic [31:0] va, input logic sup);
      logic [SET_WIDTH-1:0] idx;
      logic [31:0]          m;
      logic [31:0]          t;
      logic                 hit;
      logic                 sxe;
      logic                 uxe;
      idx = va[13 +: SET_WIDTH];
      m   = model_match[idx];
      t   = model_trans[idx];
      hit = m[0] && (m[31:13] == va[31:13]);
      if (hit) begin
         exp_phys = {t[31:13], va[12:0]};
         exp_ci   = t[1];
         sxe      = t[6];
         uxe      = t[7];
      end else begin
         exp_phys = {8'h00, va[23:0]};
         exp_ci   = 1'b0;
         sxe      = 1'b0;
         uxe      = 1'b0;
      end
      exp_miss = !hit;
      exp_pf   = sup ? !sxe : !uxe;
   endtask

   // Index edge first, then the compare cycle
   task automatic lookup(input logic [31:0] va, input logic sup);
      @(negedge clk);
      virt_addr_i       = va;
      supervisor_mode_i = sup;
      @(negedge clk);
      virt_addr_match_i = va;
      set_expect(va, sup);
      lk_check = 1'b1;
      @(negedge clk);
      lk_check = 1'b0;
   endtask

   initial begin
      for (int c = 0; c < MAX_CYCLES; c++) begin
         @(posedge clk);
      end
      $display("Simulation did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      logic [31:0]          w0;
      logic [31:0]          w1;
      logic [18:0]          vpn;
      logic [18:0]          ppn;
      logic [SET_WIDTH-1:0] idx;
      logic [12:0]          offs;
      clk               = 1'b0;
      rst               = 1'b1;
      enable_i          = 1'b1;
      supervisor_mode_i = 1'b1;
      virt_addr_i       = '0;
      virt_addr_match_i = '0;
      spr_addr_i        = '0;
      spr_we_i          = 1'b0;
      spr_stb_i         = 1'b0;
      spr_dat_i         = '0;
      lk_check          = 1'b0;
      rd_check          = 1'b0;
      value_errors      = 0;
      timeout_errors    = 0;
      seed              = 69;
      test_name         = "fill";
      repeat (2) @(negedge clk);
      rst = 1'b0;

      // Known contents everywhere with all match entries invalid
      for (int i = 0; i < ENTRIES; i++) begin
         w0 = 32'(i) * 32'h9e37_79b9;
         w1 = 32'(i) * 32'h85eb_ca6b;
         write_entry(SET_WIDTH'(i), w0 & ~32'h1, w1);
      end

      test_name = "readback";
      repeat (8) begin
         idx = SET_WIDTH'($random(seed));
         w0  = $random(seed);
         w1  = $random(seed);
         write_entry(idx, w0, w1);
         spr_read(16'h1200 + 16'(idx), w0, 1'b1);
         spr_read(16'h1280 + 16'(idx), w1, 1'b1);
      end

      test_name = "hit";
      repeat (6) begin
         idx  = SET_WIDTH'($random(seed));
         vpn  = {13'($random(seed)), idx};
         ppn  = 19'($random(seed));
         offs = 13'($random(seed));
         write_entry(idx, make_match(vpn, 1'b1),
                     make_trans(ppn, 1'b1, 1'b1, 1'($random(seed))));
         lookup({vpn, offs}, 1'b1);
      end

      test_name = "miss";
      idx  = SET_WIDTH'($random(seed));
      vpn  = {13'($random(seed)), idx};
      offs = 13'($random(seed));
      write_entry(idx, make_match(vpn, 1'b0), make_trans(19'h7_ffff, 1'b1, 1'b1, 1'b1));
      lookup({vpn, offs}, 1'b1);
      write_entry(idx, make_match(vpn, 1'b1), make_trans(19'h1_2345, 1'b1, 1'b1, 1'b1));
      lookup({vpn ^ 19'h4_0000, offs}, 1'b0);

      test_name = "permissions";
      for (int p = 0; p < 4; p++) begin
         idx = SET_WIDTH'($random(seed));
         vpn = {13'($random(seed)), idx};
         ppn = 19'($random(seed));
         write_entry(idx, make_match(vpn, 1'b1),
                     make_trans(ppn, p[1], p[0], 1'b0));
         lookup({vpn, 13'($random(seed))}, 1'b1);
         lookup({vpn, 13'($random(seed))}, 1'b0);
      end

      test_name = "busy";
      spr_write(16'h1200 + 16'd5, make_match(19'h0_0005, 1'b0));
      model_match[5] = make_match(19'h0_0005, 1'b0);
      @(negedge clk);
      enable_i = 1'b0;
      spr_write(16'h1280 + 16'd5, 32'h0000_00c2);
      model_trans[5] = 32'h0000_00c2;
      @(negedge clk);
      enable_i = 1'b1;

      test_name = "decode";
      spr_read(16'h0a00 + 16'd3, 32'h0, 1'b0);
      spr_read(16'h1010, 32'h0, 1'b1);

      repeat (2) @(negedge clk);
      $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: immu_top.f
hw/immu_pkg.sv
hw/itlb_port_if.sv
hw/immu_spr_ctrl.sv
hw/itlb_match_array.sv
hw/itlb_trans_array.sv
hw/immu_translate.sv
hw/immu_top.sv
verification/immu_tb.sv
